// File: norm_defs.svh
`ifndef NORM_DEFS_SVH
`define NORM_DEFS_SVH

// biased exponent width of the result
`define NE 8

// width of the aligned addends and of the quotient
// raw sum carries one extra bit for the carry out
`define SUMW 24

// output mantissa width, leading one included
`define MANTW 16

// normalization window
// one guard position above the expected leading one, one below
`define NORMSHIFTSZ (`SUMW + 3)

// shift amount width
`define LOGNORMSHIFTSZ ($clog2(`NORMSHIFTSZ))

`endif

// File: normPkg.sv
`include "norm_defs.svh"

package normPkg;

  // operation kinds
  // bit 0 selects subtraction inside the fused-add pair
  typedef enum logic [1:0] {
    opFmaAdd = 2'd0,
    opFmaSub = 2'd1,
    opDiv    = 2'd2
  } opKind;

  // request as it arrives at the stage
  // opDiv carries the quotient in addendA, addendB unused
  typedef struct packed {
    opKind             op;
    logic [`SUMW-1:0]  addendA;
    logic [`SUMW-1:0]  addendB;
    logic [`NE-1:0]    exponent;
  } normReq;

  ////////////////////////////////////////
  // one operation between stage 1 and 2
  ////////////////////////////////////////
  typedef struct packed {
    logic [`SUMW:0]                rawSum;
    logic [`LOGNORMSHIFTSZ-1:0]    shiftAmt;
    // two's complement, two bits wider than the biased exponent
    // fma: exponent after the predicted shift, div: input exponent
    logic [`NE+1:0]                exponent;
    logic                          fmaOp;
    logic                          divOp;
    logic                          divResSubnorm;
    // fma result looked subnormal before the lza correction
    logic                          preResultSubnorm;
    logic                          sumZero;
  } normStage;

  // normalized result
  typedef struct packed {
    logic [`MANTW-1:0] mant;
    logic [`NE-1:0]    exp;
  } normRes;

endpackage

// File: lzaPredict.sv
`include "norm_defs.svh"

module lzaPredict (
  input  logic [`SUMW-1:0]           addendA,
  input  logic [`SUMW-1:0]           addendB,
  input  logic                       sub,
  output logic [`LOGNORMSHIFTSZ-1:0] shiftAmt
);

  // operands widened so the carry position is covered
  logic [`SUMW:0] opA;
  logic [`SUMW:0] opB;
  logic [`SUMW:0] propStr;
  logic [`SUMW:0] genStr;
  logic [`SUMW:0] killStr;
  logic [`SUMW:0] propUp;
  logic [`SUMW:0] marker;
  int             leadPos;
  int             zeroCnt;

  assign opA = {1'b0, addendA};
  // subtraction sees the inverted subtrahend
  assign opB = sub ? ~{1'b0, addendB} : {1'b0, addendB};

  ////////////////////////////////////////
  // propagate / generate / kill string
  ////////////////////////////////////////
  assign propStr = opA ^ opB;
  assign genStr  = opA & opB;
  assign killStr = ~opA & ~opB;

  // propagate one position up
  // above the msb both operands are zero, an equal digit in sub mode
  assign propUp = {1'b1, propStr[`SUMW:1]};

  // add: first position where either addend has a one
  //   true leading one is there or one above
  // sub (a >= b): end of the nonzero digit run below the top one
  //   true leading one is there or one above as well
  assign marker = sub ? (~propUp & ~killStr) : (propStr | genStr);

  ////////////////////////////////////////
  // leading zero count of the marker
  ////////////////////////////////////////
  always_comb begin
    // no marker at all counts as sumw+1 zeros
    leadPos = -1;
    for (int i = 0; i <= `SUMW; i++) begin
      if (marker[i]) begin
        leadPos = i;
      end
    end
  end

  // predicted shift is measured from the carry bit
  assign zeroCnt  = `SUMW - leadPos;
  assign shiftAmt = zeroCnt[`LOGNORMSHIFTSZ-1:0];

endmodule

// File: normShifter.sv
`include "norm_defs.svh"

module normShifter (
  input  logic [`SUMW:0]             rawSum,
  input  logic [`LOGNORMSHIFTSZ-1:0] shiftAmt,
  output logic [`NORMSHIFTSZ-1:0]    shifted
);

  // one row per shift amount bit, row 0 is the unshifted input
  logic [`NORMSHIFTSZ-1:0] level [0:`LOGNORMSHIFTSZ];

  // raw sum sits one below the top guard bit
  // a shift of zero puts the carry bit at normshiftsz-2
  // zero fill on the low side
  assign level[0] = {1'b0, rawSum, 1'b0};

  ////////////////////////////////////////
  // logarithmic left barrel shift
  ////////////////////////////////////////
  for (genvar i = 0; i < `LOGNORMSHIFTSZ; i++) begin : gLevel
    // row i moves by 2**i when its select bit is set
    assign level[i+1] = shiftAmt[i] ? (level[i] << (2**i)) : level[i];
  end

  // a correct prediction leaves the leading one at normshiftsz-2
  // one too many lands it in the top guard bit
  assign shifted = level[`LOGNORMSHIFTSZ];

endmodule

// File: shiftCorrection.sv
`include "norm_defs.svh"

module shiftCorrection (
  input  logic [`NORMSHIFTSZ-1:0] shifted,
  input  normPkg::normStage       stage,
  output logic [`MANTW-1:0]       mant,
  output logic [`NE+1:0]          exp
);

  logic           lzaPlus1;
  logic           resSubnorm;
  logic           rightShift;
  logic           killExp;
  logic [`NE+1:0] fmaExp;
  logic [`NE+1:0] divExp;

  // leading one in the top guard bit
  // fma: lza shifted one too far
  // div: quotient is at least one
  assign lzaPlus1 = shifted[`NORMSHIFTSZ-1];

  // capped shift still reached the normal position
  // so the result is normal with exponent one
  assign resSubnorm = stage.preResultSubnorm & ~shifted[`NORMSHIFTSZ-2];

  ////////////////////////////////////////
  // mantissa select
  ////////////////////////////////////////
  // the top slice serves three cases
  //   lza overshoot, fma subnormal placement,
  //   and the unshifted quotient of a subnormal divide
  assign rightShift = lzaPlus1 |
                      (stage.fmaOp ? resSubnorm : stage.divResSubnorm);

  assign mant = rightShift ? shifted[`NORMSHIFTSZ-1 -: `MANTW]
                           : shifted[`NORMSHIFTSZ-2 -: `MANTW];

  ////////////////////////////////////////
  // exponent select
  ////////////////////////////////////////
  // zero sum and true subnormal both give exponent 0
  assign killExp = stage.sumZero | resSubnorm;

  // fma: bump by one when the shift overshot
  assign fmaExp = killExp ? '0
                          : stage.exponent + {{(`NE+1){1'b0}}, lzaPlus1};

  // div: quotient below one loses one exponent step
  assign divExp = stage.divResSubnorm ? '0
                                      : stage.exponent - {{(`NE+1){1'b0}}, ~lzaPlus1};

  assign exp = stage.divOp ? divExp : fmaExp;

endmodule

// File: normCtrl.sv
`include "norm_defs.svh"

module normCtrl (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       inValid,
  input  normPkg::normReq            req,
  input  logic [`LOGNORMSHIFTSZ-1:0] lzaShift,
  input  logic [`MANTW-1:0]          corrMant,
  input  logic [`NE+1:0]             corrExp,
  output normPkg::normStage          stage,
  output logic                       outValid,
  output normPkg::normRes            res
);
  import normPkg::*;

  logic                       fmaOp;
  logic                       divOp;
  logic [`SUMW:0]             rawSum;
  logic [`NE+1:0]             expExt;
  logic [`NE+1:0]             shiftExt;
  logic                       fmaSubnorm;
  logic                       divSubnorm;
  logic [`LOGNORMSHIFTSZ-1:0] cappedShift;
  logic                       valid1;
  normStage                   stageNext;

  ////////////////////////////////////////
  // stage 1 decode and raw result
  ////////////////////////////////////////
  assign fmaOp = (req.op == opFmaAdd) | (req.op == opFmaSub);
  assign divOp = req.op == opDiv;

  always_comb begin
    case (req.op)
      opFmaAdd: rawSum = {1'b0, req.addendA} + {1'b0, req.addendB};
      opFmaSub: rawSum = {1'b0, req.addendA} - {1'b0, req.addendB};
      // quotient unit bit lands on bit sumw
      opDiv:    rawSum = {req.addendA, 1'b0};
      default:  rawSum = '0;
    endcase
  end

  assign expExt   = {2'b00, req.exponent};
  assign shiftExt = {{(`NE+2-`LOGNORMSHIFTSZ){1'b0}}, lzaShift};

  // shift counts from the carry bit, so exponent+1-shift is the new exponent
  // stop the shift once that would drop to zero or below
  assign fmaSubnorm  = shiftExt > expExt;
  assign cappedShift = fmaSubnorm ? req.exponent[`LOGNORMSHIFTSZ-1:0] : lzaShift;

  // divide exponent drops by one for a quotient below one
  assign divSubnorm = req.addendA[`SUMW-1] ? (req.exponent == '0)
                                           : (req.exponent <= {{(`NE-1){1'b0}}, 1'b1});

  always_comb begin
    stageNext.rawSum           = rawSum;
    // divider always uses a fixed shift of one
    stageNext.shiftAmt         = divOp ? {{(`LOGNORMSHIFTSZ-1){1'b0}}, 1'b1} : cappedShift;
    stageNext.exponent         = divOp ? expExt
                                       : expExt + {{(`NE+1){1'b0}}, 1'b1} -
                                         {{(`NE+2-`LOGNORMSHIFTSZ){1'b0}}, cappedShift};
    stageNext.fmaOp            = fmaOp;
    stageNext.divOp            = divOp;
    stageNext.divResSubnorm    = divOp & divSubnorm;
    stageNext.preResultSubnorm = fmaOp & fmaSubnorm;
    stageNext.sumZero          = fmaOp & (rawSum == '0);
  end

  ////////////////////////////////////////
  // pipeline registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid1   <= 1'b0;
      outValid <= 1'b0;
    end else begin
      valid1   <= inValid;
      outValid <= valid1;
    end
  end

  // stage 1 payload, loads on an issued op only
  always_ff @(posedge clk) begin
    if (inValid) begin
      stage <= stageNext;
    end
  end

  // stage 2 result, exponent cut back to ne bits
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      res <= '0;
    end else if (valid1) begin
      res.mant <= corrMant;
      res.exp  <= corrExp[`NE-1:0];
    end
  end

endmodule

// File: normTop.sv
`include "norm_defs.svh"

module normTop (
  input  logic            clk,
  input  logic            rstN,
  input  logic            inValid,
  input  normPkg::normReq req,
  output logic            outValid,
  output normPkg::normRes res
);
  import normPkg::*;

  // stage 1 prediction
  logic [`LOGNORMSHIFTSZ-1:0] lzaShift;

  // registered operation feeding stage 2
  normStage                   stage;

  // stage 2 datapath
  logic [`NORMSHIFTSZ-1:0]    shifted;
  logic [`MANTW-1:0]          corrMant;
  logic [`NE+1:0]             corrExp;

  ////////////////////////////////////////
  // control and pipeline registers
  ////////////////////////////////////////
  normCtrl normCtrl_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .req      (req),
    .lzaShift (lzaShift),
    .corrMant (corrMant),
    .corrExp  (corrExp),
    .stage    (stage),
    .outValid (outValid),
    .res      (res)
  );

  // shift prediction straight off the request
  // op bit 0 marks subtraction, divide output is ignored
  lzaPredict lzaPredict_i (
    .addendA  (req.addendA),
    .addendB  (req.addendB),
    .sub      (req.op[0]),
    .shiftAmt (lzaShift)
  );

  ////////////////////////////////////////
  // normalization datapath
  ////////////////////////////////////////
  normShifter normShifter_i (
    .rawSum   (stage.rawSum),
    .shiftAmt (stage.shiftAmt),
    .shifted  (shifted)
  );

  shiftCorrection shiftCorrection_i (
    .shifted  (shifted),
    .stage    (stage),
    .mant     (corrMant),
    .exp      (corrExp)
  );

endmodule

// File: normTop_assert.sv
`include "norm_defs.svh"

module normTop_assert (
  input logic            clk,
  input logic            rstN,
  input logic            inValid,
  input logic            outValid,
  input normPkg::normRes res
);
  timeunit 1ns;
  timeprecision 1ps;

  int assertFails = 0;

  // issue reaches the output two edges later
  issueToResult: assert property (@(posedge clk) disable iff (!rstN)
    inValid |-> ##2 outValid)
    else begin
      $error("issued op gave no result two cycles later");
      assertFails++;
    end

  // and nothing comes out without an issue
  resultFromIssue: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> $past(inValid, 2))
    else begin
      $error("result without an issue two cycles earlier");
      assertFails++;
    end

  quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
    else begin
      $error("result valid during reset");
      assertFails++;
    end

  // normal result carries its leading one in the mantissa msb
  normalForm: assert property (@(posedge clk) disable iff (!rstN)
    (outValid && res.exp != '0) |-> res.mant[`MANTW-1])
    else begin
      $error("normal result without leading one");
      assertFails++;
    end

endmodule

// File: normTop_tb.sv
`include "norm_defs.svh"

module normTop_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import normPkg::*;

  // phase lengths, the timeout follows from their sum
  localparam int numAdd = 40;
  localparam int numSub = 40;
  localparam int numSubnorm = 30;
  localparam int numDiv = 30;
  localparam int numMixed = 64;
  localparam int numOps = numAdd + numSub + numSubnorm + numDiv + numMixed;
  localparam int timeoutCycles = 2 * numOps + 50;

  logic    clk;
  logic    rstN;
  logic    inValid;
  normReq  req;
  logic    outValid;
  normRes  res;

  int      seed = 32'h6785b138;
  int      cycleCnt = 0;
  int      mantErrors = 0;
  int      expErrors = 0;
  int      otherErrors = 0;
  // expected results in issue order
  normRes  expQ[$];

  normTop normTop_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .req      (req),
    .outValid (outValid),
    .res      (res)
  );

  bind normTop normTop_assert normTop_assert_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .outValid (outValid),
    .res      (res)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  function automatic logic [31:0] nextRand();
    nextRand = $random(seed);
  endfunction

  ////////////////////////////////////////
  // expected result
  ////////////////////////////////////////
  function automatic normRes refNorm(input normReq r);
    normRes         o;
    logic [`SUMW:0] s;
    logic [`SUMW:0] t;
    int             lead;
    int             e;
    o = '0;
    if (r.op == opDiv) begin
      // quotient unit bit at sumw
      s = {r.addendA, 1'b0};
      if (s[`SUMW]) begin
        o.mant = s[`SUMW -: `MANTW];
        o.exp  = r.exponent;
      end else if (r.exponent > 8'd1) begin
        o.mant = s[`SUMW-1 -: `MANTW];
        o.exp  = r.exponent - 8'd1;
      end else begin
        // subnormal quotient stays unshifted
        o.mant = s[`SUMW -: `MANTW];
      end
      return o;
    end
    if (r.op == opFmaAdd) begin
      s = {1'b0, r.addendA} + {1'b0, r.addendB};
    end else begin
      s = {1'b0, r.addendA} - {1'b0, r.addendB};
    end
    // exact zero gives all zero
    if (s == '0) begin
      return o;
    end
    lead = 0;
    for (int i = 0; i <= `SUMW; i++) begin
      if (s[i]) begin
        lead = i;
      end
    end
    e = int'(r.exponent) + lead - (`SUMW - 1);
    if (e >= 1) begin
      // leading one moved up to bit sumw
      t = s << (`SUMW - lead);
      o.mant = t[`SUMW -: `MANTW];
      o.exp  = e[`NE-1:0];
    end else begin
      // shift by exponent-1, exponent 0 means one step right
      t = (r.exponent == '0) ? (s >> 1) : (s << (r.exponent - 8'd1));
      o.mant = t[`SUMW -: `MANTW];
    end
    return o;
  endfunction

  // random request of one kind
  // sub keeps a >= b with a close b, div keeps the quotient in [0.5, 2)
  function automatic normReq randomReq(input opKind op, input logic smallExp);
    normReq      r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] e;
    a = nextRand();
    b = nextRand();
    e = nextRand();
    r.op = op;
    r.addendA = a[`SUMW-1:0];
    r.addendB = b[`SUMW-1:0];
    if (smallExp) begin
      r.exponent = e[7:0] % ((op == opDiv) ? 8'd3 : 8'd12);
    end else begin
      r.exponent = 8'd30 + e[7:0] % 8'd220;
    end
    if (op == opFmaSub) begin
      r.addendA[`SUMW-1] = 1'b1;
      // difference width is random, wide shifts give an exact zero
      r.addendB = r.addendA - ((b[`SUMW-1:0] >> 1) >> b[28:24]);
    end else if (op == opDiv) begin
      r.addendA[`SUMW-1] = a[31];
      r.addendA[`SUMW-2] = 1'b1;
      r.addendB = '0;
    end
    return r;
  endfunction

  task automatic issueOp(input normReq r);
    @(negedge clk);
    inValid = 1'b1;
    req = r;
    expQ.push_back(refNorm(r));
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(negedge clk);
      inValid = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  task automatic checkMant(input logic [`MANTW-1:0] got, input logic [`MANTW-1:0] want);
    if (got !== want) begin
      mantErrors++;
      $display("Mismatch res.mant: got 0x%h expected 0x%h at %0t", got, want, $time);
    end
  endtask

  task automatic checkExp(input logic [`NE-1:0] got, input logic [`NE-1:0] want);
    if (got !== want) begin
      expErrors++;
      $display("Mismatch res.exp: got 0x%h expected 0x%h at %0t", got, want, $time);
    end
  endtask

  // outputs settle after the rising edge, so look at the falling one
  always @(negedge clk) begin : compare
    normRes want;
    if (rstN && outValid) begin
      if (expQ.size() == 0) begin
        otherErrors++;
        $display("result came out at %0t with no operation outstanding", $time);
      end else begin
        want = expQ.pop_front();
        checkMant(res.mant, want.mant);
        checkExp(res.exp, want.exp);
      end
    end
  end

  task automatic finishRun();
    int assertErrors;
    assertErrors = normTop_i.normTop_assert_i.assertFails;
    $display("errors: mant %0d, exp %0d, other %0d, assertion %0d",
             mantErrors, expErrors, otherErrors, assertErrors);
    if (mantErrors + expErrors + otherErrors + assertErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  initial begin : watchdog
    wait (cycleCnt >= timeoutCycles);
    otherErrors++;
    $display("run stopped after %0d cycles with %0d results still missing",
             cycleCnt, expQ.size());
    finishRun();
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin : stimulus
    logic [31:0] d;
    clk = 1'b0;
    rstN = 1'b0;
    inValid = 1'b0;
    req = '0;
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    idleCycles(2);
    // additions, carry out comes from both top bits set
    for (int i = 0; i < numAdd; i++) issueOp(randomReq(opFmaAdd, 1'b0));
    idleCycles(2);
    // close subtractions, lza correction
    for (int i = 0; i < numSub; i++) issueOp(randomReq(opFmaSub, 1'b0));
    idleCycles(2);
    // small exponents, subnormal and zero results
    for (int i = 0; i < numSubnorm; i++) issueOp(randomReq(opFmaSub, 1'b1));
    idleCycles(2);
    // quotients, every other one with a tiny exponent
    for (int i = 0; i < numDiv; i++) issueOp(randomReq(opDiv, i[0]));
    idleCycles(2);
    // mixed bursts of eight with random gaps
    for (int i = 0; i < numMixed; i++) begin
      d = nextRand();
      issueOp(randomReq(opKind'(d[1:0] % 2'd3), d[2]));
      if (i % 8 == 7) begin
        idleCycles(int'(d[5:4]));
      end
    end
    idleCycles(1);
    while (expQ.size() != 0) @(negedge clk);
    idleCycles(3);
    finishRun();
  end

endmodule

// File: normTop.f
+incdir+.
normPkg.sv
lzaPredict.sv
normShifter.sv
shiftCorrection.sv
normCtrl.sv
normTop.sv
normTop_assert.sv
normTop_tb.sv

// File: Bender.yml
package:
  name: normTop

sources:
  - include_dirs:
      - .
    files:
      - normPkg.sv
      - lzaPredict.sv
      - normShifter.sv
      - shiftCorrection.sv
      - normCtrl.sv
      - normTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - normTop_assert.sv
      - normTop_tb.sv
